//--- fixed_prior_arb.sv
// ==========================================================
// Fixed-priority arbiter
// One-hot grant to the lowest-indexed request, all zero
// when nothing is requested
// ==========================================================
`timescale 1ns/1ps

module fixed_prior_arb
    import pool_mem_pkg::*;
(
    input  logic [pool_core-1:0] req,
    output logic [pool_core-1:0] gnt
);

    always_comb begin
        // Two's complement isolates the lowest set bit
        gnt = req & (~req + 1'b1);

        // Never more than one winner
        a_gnt_onehot: assert ($isunknown(gnt) || $onehot0(gnt))
            else $error("Arbiter grant not one-hot");
    end

endmodule

//--- glb_bank.sv
// ==========================================================
// Global buffer bank
// 1024-row activation store with an external write port
// and a read port serving one request at a time
// ==========================================================
`timescale 1ns/1ps

module glb_bank
    import pool_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Loading port
    input  logic       wr_en,
    input  glb_addr_t  wr_addr,
    input  ofm_row_t   wr_data,
    // Read address channel
    input  logic       addr_vld,
    input  glb_addr_t  addr,
    output logic       addr_rdy,
    // Read data channel
    output logic       ofm_vld,
    output ofm_row_t   ofm,
    input  logic       ofm_rdy
);

    ofm_row_t   mem [0:glb_depth-1];
    glb_state_t state;
    glb_state_t state_nxt;
    glb_addr_t  addr_q;
    ofm_row_t   ofm_q;

    // ======================================================
    // Read state machine
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= glb_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            glb_idle: begin
                // Accept one address
                if (addr_vld) begin
                    state_nxt = glb_read;
                end
            end
            // Array access takes exactly one cycle
            glb_read: state_nxt = glb_resp;
            glb_resp: begin
                // Hold the row until taken
                if (ofm_rdy) begin
                    state_nxt = glb_idle;
                end
            end
            default: state_nxt = glb_idle;
        endcase
    end

    assign addr_rdy = (state == glb_idle);
    assign ofm_vld  = (state == glb_resp);
    assign ofm      = ofm_q;

    // ======================================================
    // Storage and datapath
    // ======================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Address latched on accept
    always_ff @(posedge clk) begin
        if (addr_vld && addr_rdy) begin
            addr_q <= addr;
        end
    end

    // Row sampled in glb_read, held through glb_resp
    always_ff @(posedge clk) begin
        if (state == glb_read) begin
            ofm_q <= mem[addr_q];
        end
    end

    // Row must not move while the receiver stalls
    a_ofm_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_vld && !ofm_rdy |=> $stable(ofm))
        else $error("GLB row changed under back-pressure");

endmodule

//--- mem_if_ctrl.sv
// ==========================================================
// Memory interface controller
// Arbitrates core read requests, queues tagged commands
// toward the GLB and queues tagged rows back out
// ==========================================================
`timescale 1ns/1ps

module mem_if_ctrl
    import pool_mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    // Core requests
    input  logic [pool_core-1:0]       req_vld,
    input  glb_addr_t [pool_core-1:0]  req_addr,
    output logic [pool_core-1:0]       req_rdy,
    // GLB address channel
    output logic                       glb_addr_vld,
    output glb_addr_t                  glb_addr,
    input  logic                       glb_addr_rdy,
    // GLB data channel
    input  ofm_row_t                   glb_ofm,
    input  logic                       glb_ofm_vld,
    output logic                       glb_ofm_rdy,
    // Tagged rows to dispatcher
    output logic                       tagged_vld,
    output port_id_t                   tagged_port,
    output ofm_row_t                   tagged_ofm,
    input  logic                       tagged_rdy
);

    logic [pool_core-1:0] gnt;
    port_id_t             arb_port;
    port_id_t             rd_port;
    // Tag of the read now in the GLB
    port_id_t             rd_port_q;
    logic                 rd_pend;
    logic                 cmd_empty;
    logic                 cmd_full;
    logic                 out_empty;
    logic                 out_full;
    logic                 cmd_push;
    logic                 cmd_pop;
    logic                 out_push;
    logic                 out_pop;

    // ======================================================
    // Request arbitration
    // ======================================================
    fixed_prior_arb u_arb (
        .req (req_vld),
        .gnt (gnt)
    );

    // Grant to core index
    always_comb begin
        arb_port = '0;
        for (int i = 0; i < pool_core; i++) begin
            if (gnt[i]) begin
                arb_port = port_id_t'(i);
            end
        end
    end

    // Winner only, and only with room in the queue
    assign req_rdy  = gnt & {pool_core{!cmd_full}};
    assign cmd_push = |(req_vld & req_rdy);

    // Command queue, core index above the address
    sync_fifo_fwft #(
        .data_width (cmd_width),
        .addr_width (fifo_addr_width)
    ) u_cmd_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (cmd_push),
        .pop      (cmd_pop),
        .data_in  ({arb_port, req_addr[arb_port]}),
        .data_out ({rd_port, glb_addr}),
        .empty    (cmd_empty),
        .full     (cmd_full)
    );

    assign glb_addr_vld = !cmd_empty;
    assign cmd_pop      = glb_addr_vld && glb_addr_rdy;

    // ======================================================
    // Tag tracking, single GLB read in flight
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_port_q <= '0;
            rd_pend   <= 1'b0;
        end else if (cmd_pop) begin
            rd_port_q <= rd_port;
            rd_pend   <= 1'b1;
        end else if (out_push) begin
            rd_pend   <= 1'b0;
        end
    end

    // Output queue, tag prepended to the row
    assign glb_ofm_rdy = !out_full;
    assign out_push    = glb_ofm_vld && glb_ofm_rdy;

    sync_fifo_fwft #(
        .data_width (out_width),
        .addr_width (fifo_addr_width)
    ) u_out_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (out_push),
        .pop      (out_pop),
        .data_in  ({rd_port_q, glb_ofm}),
        .data_out ({tagged_port, tagged_ofm}),
        .empty    (out_empty),
        .full     (out_full)
    );

    assign tagged_vld = !out_empty;
    assign out_pop    = tagged_vld && tagged_rdy;

    // A GLB response must belong to a sent command
    a_rsp_has_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        glb_ofm_vld |-> rd_pend)
        else $error("GLB response with no read outstanding");

endmodule

//--- ofm_dispatch.sv
// ==========================================================
// Output row dispatcher
// Steers each tagged row to the valid of its core and
// returns that core's ready
// ==========================================================
`timescale 1ns/1ps

module ofm_dispatch
    import pool_mem_pkg::*;
(
    // Tagged rows from the controller
    input  logic                 tagged_vld,
    input  port_id_t             tagged_port,
    input  ofm_row_t             tagged_ofm,
    output logic                 tagged_rdy,
    // Per-core outputs
    output logic [pool_core-1:0] core_ofm_vld,
    output ofm_row_t             core_ofm,
    input  logic [pool_core-1:0] core_ofm_rdy
);

    // Row bus shared by all cores
    assign core_ofm = tagged_ofm;

    // Only the addressed core can take the row
    assign tagged_rdy = core_ofm_rdy[tagged_port];

    always_comb begin
        // Tag decode, quiet when nothing to send
        core_ofm_vld = '0;
        if (tagged_vld) begin
            core_ofm_vld[tagged_port] = 1'b1;
        end

        // At most one core addressed
        a_vld_onehot: assert ($isunknown(core_ofm_vld) || $onehot0(core_ofm_vld))
            else $error("Dispatcher valid not one-hot");
    end

endmodule

//--- pool_mem_pkg.sv
// ==========================================================
// Pooling memory package
// Shared widths, core count, row types and the GLB read
// state encoding for the activation read path
// ==========================================================
package pool_mem_pkg;

    // Number of pooling cores sharing the GLB
    localparam int unsigned pool_core = 4;
    // Activations per GLB row and bits per activation
    localparam int unsigned comp_lanes = 8;
    localparam int unsigned act_width = 8;
    // GLB row address, 1024 rows
    localparam int unsigned idx_width = 10;
    localparam int unsigned glb_depth = 1 << idx_width;
    // Core index width
    localparam int unsigned port_width = $clog2(pool_core);
    // Both controller FIFOs hold 4 entries
    localparam int unsigned fifo_addr_width = 2;

    // Derived payload widths
    localparam int unsigned ofm_width = comp_lanes * act_width;
    localparam int unsigned cmd_width = port_width + idx_width;
    localparam int unsigned out_width = port_width + ofm_width;

    typedef logic [idx_width-1:0]  glb_addr_t;
    typedef logic [ofm_width-1:0]  ofm_row_t;
    typedef logic [port_width-1:0] port_id_t;

    // GLB read sequencing, one read in flight
    typedef enum logic [1:0] {
        glb_idle = 2'd0,
        glb_read = 2'd1,
        glb_resp = 2'd2
    } glb_state_t;

endpackage

//--- pool_mem_top.f
pool_mem_pkg.sv
sync_fifo_fwft.sv
fixed_prior_arb.sv
mem_if_ctrl.sv
glb_bank.sv
ofm_dispatch.sv
pool_mem_top.sv
tb_pool_mem_top.sv

//--- pool_mem_top.sv
// ==========================================================
// Pooling memory read path, top level
// Core requests -> controller -> GLB bank -> controller
// -> dispatcher -> cores
// Pipeline, no stalls: accept cycle, command head, glb_read,
// glb_resp, core_ofm_vld; five cycles inclusive
// ==========================================================
`timescale 1ns/1ps

module pool_mem_top
    import pool_mem_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // Core read requests
    input  logic [pool_core-1:0]      req_vld,
    input  glb_addr_t [pool_core-1:0] req_addr,
    output logic [pool_core-1:0]      req_rdy,
    // Rows back to cores
    output logic [pool_core-1:0]      core_ofm_vld,
    output ofm_row_t                  core_ofm,
    input  logic [pool_core-1:0]      core_ofm_rdy,
    // GLB loading
    input  logic                      wr_en,
    input  glb_addr_t                 wr_addr,
    input  ofm_row_t                  wr_data
);

    // Controller <-> GLB
    logic      glb_addr_vld;
    logic      glb_addr_rdy;
    glb_addr_t glb_addr;
    logic      glb_ofm_vld;
    logic      glb_ofm_rdy;
    ofm_row_t  glb_ofm;

    // Controller -> dispatcher
    logic      tagged_vld;
    logic      tagged_rdy;
    port_id_t  tagged_port;
    ofm_row_t  tagged_ofm;

    mem_if_ctrl u_mem_if_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld      (req_vld),
        .req_addr     (req_addr),
        .req_rdy      (req_rdy),
        .glb_addr_vld (glb_addr_vld),
        .glb_addr     (glb_addr),
        .glb_addr_rdy (glb_addr_rdy),
        .glb_ofm      (glb_ofm),
        .glb_ofm_vld  (glb_ofm_vld),
        .glb_ofm_rdy  (glb_ofm_rdy),
        .tagged_vld   (tagged_vld),
        .tagged_port  (tagged_port),
        .tagged_ofm   (tagged_ofm),
        .tagged_rdy   (tagged_rdy)
    );

    glb_bank u_glb_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .addr_vld (glb_addr_vld),
        .addr     (glb_addr),
        .addr_rdy (glb_addr_rdy),
        .ofm_vld  (glb_ofm_vld),
        .ofm      (glb_ofm),
        .ofm_rdy  (glb_ofm_rdy)
    );

    ofm_dispatch u_ofm_dispatch (
        .tagged_vld   (tagged_vld),
        .tagged_port  (tagged_port),
        .tagged_ofm   (tagged_ofm),
        .tagged_rdy   (tagged_rdy),
        .core_ofm_vld (core_ofm_vld),
        .core_ofm     (core_ofm),
        .core_ofm_rdy (core_ofm_rdy)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pooling memory testbench with Verilator.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

top=tb_pool_mem_top
obj_dir=obj_dir
log=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module "${top}" -f pool_mem_top.f \
        --Mdir "${obj_dir}" -o "${top}"; then
    echo "Build failed"
    exit 1
fi

if ! "./${obj_dir}/${top}" > "${log}" 2>&1; then
    echo "Simulation exited with an error, see ${log}"
    cat "${log}"
    exit 1
fi

cat "${log}"

if grep -q "=== PASS ===" "${log}"; then
    echo "Result: simulation passed"
    exit 0
else
    echo "Result: simulation failed"
    exit 1
fi

//--- sync_fifo_fwft.sv
// ==========================================================
// Synchronous FIFO, first-word fall-through
// Head word is visible on data_out whenever not empty,
// no read cycle needed before pop
// ==========================================================
`timescale 1ns/1ps

module sync_fifo_fwft #(
    parameter int unsigned data_width = 8,
    parameter int unsigned addr_width = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic                  pop,
    input  logic [data_width-1:0] data_in,
    output logic [data_width-1:0] data_out,
    output logic                  empty,
    output logic                  full
);

    // Storage, payload only
    logic [data_width-1:0] mem [0:(1 << addr_width)-1];

    // Pointers carry one extra wrap bit
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;

    // ======================================================
    // Pointer update
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Write side
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[addr_width-1:0]] <= data_in;
        end
    end

    // Head word straight from storage
    assign data_out = mem[rd_ptr[addr_width-1:0]];

    // Same address, wrap bits tell full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                   (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    // ======================================================
    // Usage checks
    // ======================================================
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full))
        else $error("FIFO push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty))
        else $error("FIFO pop while empty");

endmodule

//--- tb_pool_mem_top.sv
// ==========================================================
// Pooling memory read path testbench
// Loads the GLB, runs a latency probe and random multi-core
// traffic with back-pressure, checks with assertions
// ==========================================================
`timescale 1ns/1ps

module tb_pool_mem_top
    import pool_mem_pkg::*;
;

    // Requests issued during random traffic
    localparam int num_reqs = 950;
    // About four times the load plus 4 cycles per row at 1/4 ready
    localparam int max_cycles = 4 * (glb_depth + 4 * num_reqs + 64);

    logic                      clk;
    logic                      rst_n;
    logic [pool_core-1:0]      req_vld;
    glb_addr_t [pool_core-1:0] req_addr;
    logic [pool_core-1:0]      req_rdy;
    logic [pool_core-1:0]      core_ofm_vld;
    ofm_row_t                  core_ofm;
    logic [pool_core-1:0]      core_ofm_rdy;
    logic                      wr_en;
    glb_addr_t                 wr_addr;
    ofm_row_t                  wr_data;

    // Reference state
    ofm_row_t             model [0:glb_depth-1];
    glb_addr_t            pend_q [pool_core][$];
    ofm_row_t             exp_row [pool_core];
    logic [pool_core-1:0] pend;
    logic [pool_core-1:0] taken;
    logic [31:0]          lfsr_q;
    logic [63:0]          rnd;
    logic                 first_cycle;
    logic                 lat_probe;
    int                   issued;
    int                   cycles;

    pool_mem_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_vld      (req_vld),
        .req_addr     (req_addr),
        .req_rdy      (req_rdy),
        .core_ofm_vld (core_ofm_vld),
        .core_ofm     (core_ofm),
        .core_ofm_rdy (core_ofm_rdy),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================
    // Helpers
    // ======================================================
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    // 32-bit Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[62:0], fb};
        end
        return r;
    endfunction

    // Expected winner is the lowest set request bit
    function automatic logic [pool_core-1:0] lowest_req(input logic [pool_core-1:0] v);
        logic [pool_core-1:0] g;
        g = '0;
        for (int i = pool_core - 1; i >= 0; i--) begin
            if (v[i]) begin
                g = '0;
                g[i] = 1'b1;
            end
        end
        return g;
    endfunction

    // Queues follow the transfers seen at each rising edge
    always @(posedge clk) begin
        for (int i = 0; i < pool_core; i++) begin
            if (core_ofm_vld[i] && core_ofm_rdy[i] && pend_q[i].size() > 0) begin
                void'(pend_q[i].pop_front());
            end
            if (req_vld[i] && req_rdy[i]) begin
                pend_q[i].push_back(req_addr[i]);
                taken[i] = 1'b1;
            end
            pend[i] = (pend_q[i].size() > 0);
            if (pend[i]) begin
                exp_row[i] = model[pend_q[i][0]];
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", max_cycles));
        end
    end

    // ======================================================
    // Checks
    // ======================================================
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || first_cycle) |-> (req_rdy == '0 && core_ofm_vld == '0))
        else report_mismatch("req_rdy or core_ofm_vld high around reset");

    a_priority: assert property (@(posedge clk) disable iff (!rst_n)
        req_rdy == '0 || req_rdy == lowest_req(req_vld))
        else report_mismatch("req_rdy not given to lowest requesting core");

    a_route_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(core_ofm_vld))
        else report_mismatch("core_ofm_vld has more than one bit set");

    // Valid in the fifth cycle counting the accept cycle
    a_min_latency: assert property (@(posedge clk) disable iff (!rst_n)
        lat_probe && (req_vld & req_rdy) != '0 |=> core_ofm_vld == '0
            ##1 core_ofm_vld == '0 ##1 core_ofm_vld == '0 ##1 core_ofm_vld != '0)
        else report_mismatch("idle-path latency is not five cycles");

    for (genvar g = 0; g < pool_core; g++) begin : g_core_chk
        a_no_stray_vld: assert property (@(posedge clk) disable iff (!rst_n)
            core_ofm_vld[g] |-> pend[g])
            else report_mismatch("valid to a core with nothing outstanding");

        a_row_data: assert property (@(posedge clk) disable iff (!rst_n)
            core_ofm_vld[g] && core_ofm_rdy[g] |-> core_ofm == exp_row[g])
            else report_mismatch("row differs from model at oldest address");

        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
            core_ofm_vld[g] && !core_ofm_rdy[g] |=> core_ofm_vld[g] && $stable(core_ofm))
            else report_mismatch("row or valid moved while core stalled");
    end

    // ======================================================
    // Stimulus driven on the falling edge
    // ======================================================
    task automatic load_glb();
        for (int a = 0; a < glb_depth; a++) begin
            rnd = rand_bits(ofm_width);
            wr_en   = 1'b1;
            wr_addr = glb_addr_t'(a);
            wr_data = rnd[ofm_width-1:0];
            model[a] = rnd[ofm_width-1:0];
            @(negedge clk);
        end
        wr_en = 1'b0;
    endtask

    // Drop each request accepted at the last rising edge
    task automatic retire_taken();
        for (int i = 0; i < pool_core; i++) begin
            if (taken[i]) begin
                req_vld[i] = 1'b0;
                taken[i]   = 1'b0;
            end
        end
    endtask

    task automatic drain();
        core_ofm_rdy = '1;
        while (req_vld != '0 || pend != '0) begin
            @(negedge clk);
            retire_taken();
        end
    endtask

    task automatic check_latency();
        lat_probe   = 1'b1;
        req_addr[2] = 10'h2a5;
        req_vld[2]  = 1'b1;
        drain();
        lat_probe   = 1'b0;
    endtask

    task automatic random_traffic();
        while (issued < num_reqs) begin
            @(negedge clk);
            retire_taken();
            for (int i = 0; i < pool_core; i++) begin
                rnd = rand_bits(1);
                if (!req_vld[i] && issued < num_reqs && rnd[0]) begin
                    rnd = rand_bits(idx_width);
                    req_addr[i] = rnd[idx_width-1:0];
                    req_vld[i]  = 1'b1;
                    issued++;
                end
                // Ready one time in four so the FIFOs fill up
                rnd = rand_bits(2);
                core_ofm_rdy[i] = &rnd[1:0];
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        req_vld      = '0;
        req_addr     = '0;
        core_ofm_rdy = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        lfsr_q       = 32'h40f3;
        pend         = '0;
        taken        = '0;
        first_cycle  = 1'b0;
        lat_probe    = 1'b0;
        issued       = 0;
        cycles       = 0;
        repeat (16) @(negedge clk);
        rst_n       = 1'b1;
        first_cycle = 1'b1;
        @(negedge clk);
        first_cycle = 1'b0;
        load_glb();
        check_latency();
        random_traffic();
        drain();
        repeat (4) @(negedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule
